/* verilog/csr_pkg.sv */
package csr_pkg;

	// Widths with a meaning of their own.
	typedef logic [11:0] csr_index_t;
	typedef logic [31:0] csr_data_t;
	typedef logic [63:0] counter_t;

	// Machine trap setup and handling.
	localparam csr_index_t CSR_MSTATUS = 12'h300;
	localparam csr_index_t CSR_MIE = 12'h304;
	localparam csr_index_t CSR_MTVEC = 12'h305;
	localparam csr_index_t CSR_MSCRATCH = 12'h340;
	localparam csr_index_t CSR_MEPC = 12'h341;
	localparam csr_index_t CSR_MCAUSE = 12'h342;
	localparam csr_index_t CSR_MIP = 12'h344;

	// Unprivileged counters, low and high halves.
	localparam csr_index_t CSR_CYCLE = 12'hC00;
	localparam csr_index_t CSR_TIME = 12'hC01;
	localparam csr_index_t CSR_INSTRET = 12'hC02;
	localparam csr_index_t CSR_CYCLEH = 12'hC80;
	localparam csr_index_t CSR_TIMEH = 12'hC81;
	localparam csr_index_t CSR_INSTRETH = 12'hC82;

	// Machine identity, read only.
	localparam csr_index_t CSR_MVENDORID = 12'hF11;
	localparam csr_index_t CSR_MARCHID = 12'hF12;
	localparam csr_index_t CSR_MIMPID = 12'hF13;
	localparam csr_index_t CSR_MHARTID = 12'hF14;

	// Standard mcause codes.
	// Interrupts carry bit 31; ecall is an exception.
	localparam csr_data_t CAUSE_EXTERNAL = 32'h8000_000B;
	localparam csr_data_t CAUSE_TIMER = 32'h8000_0007;
	localparam csr_data_t CAUSE_ECALL = 32'h0000_000B;

endpackage

/* verilog/csr_bus_if.sv */
interface csr_bus_if import csr_pkg::*; ();

	// One CSR access per cycle.
	csr_index_t index;
	csr_data_t wdata;
	logic write;
	logic read;

	// Combinational from index.
	csr_data_t rdata;

	modport requester (
		output index,
		output wdata,
		output write,
		output read,
		input rdata
	);

	modport responder (
		input index,
		input wdata,
		input write,
		input read,
		output rdata
	);

endinterface

/* verilog/csr_arbiter.sv */
module csr_arbiter import csr_pkg::*; (
	// Core pipeline port.
	input csr_index_t i_core_index,
	input csr_data_t i_core_wdata,
	input logic i_core_write,
	input logic i_core_read,
	output csr_data_t o_core_rdata,

	// Debug port.
	input csr_index_t i_dbg_index,
	input csr_data_t i_dbg_wdata,
	input logic i_dbg_write,
	input logic i_dbg_read,
	output csr_data_t o_dbg_rdata,
	output logic o_dbg_ack,

	csr_bus_if.requester bus
);

	logic core_active;
	logic dbg_active;

	assign core_active = i_core_write | i_core_read;
	assign dbg_active = i_dbg_write | i_dbg_read;

	// Core always wins the bus.
	always_comb begin
		if (core_active) begin
			bus.index = i_core_index;
			bus.wdata = i_core_wdata;
			bus.write = i_core_write;
			bus.read = i_core_read;
		end else begin
			bus.index = i_dbg_index;
			bus.wdata = i_dbg_wdata;
			bus.write = i_dbg_write;
			bus.read = i_dbg_read;
		end
	end

	// Both sides see the same read data.
	assign o_core_rdata = bus.rdata;
	assign o_dbg_rdata = bus.rdata;

	// Debug holds its strobe until acknowledged.
	assign o_dbg_ack = dbg_active & ~core_active;

endmodule

/* verilog/csr_file.sv */
module csr_file import csr_pkg::*; #(
	parameter csr_data_t VENDORID = '0,
	parameter csr_data_t ARCHID = '0,
	parameter csr_data_t IMPID = '0,
	parameter csr_data_t HARTID = '0
) (
	input logic i_clock,
	input logic i_reset,

	csr_bus_if.responder bus,

	// Counter values.
	input counter_t i_cycle,
	input counter_t i_time,
	input counter_t i_retired,

	// Interrupt sources.
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_ecall,
	input logic i_mret,

	// Interrupt issue to the core.
	input logic i_irq_dispatched,
	input csr_data_t i_irq_epc,
	output logic o_irq_pending,
	output csr_data_t o_irq_pc,
	output csr_data_t o_epc
);

	// Bit positions in mstatus, mie and mip.
	localparam int MSTATUS_MIE = 3;
	localparam int MSTATUS_MPIE = 7;
	localparam int IRQ_MSI = 3;
	localparam int IRQ_MTI = 7;
	localparam int IRQ_MEI = 11;

	typedef enum logic {
		IRQ_IDLE,
		IRQ_PENDING
	} irq_state_t;

	irq_state_t irq_state;

	logic mstatus_mie;
	logic mstatus_mpie;
	logic mie_meie;
	logic mie_mtie;
	logic mie_msie;
	logic mip_meip;
	logic mip_mtip;
	logic mip_msip;
	csr_data_t mtvec;
	csr_data_t mscratch;
	csr_data_t mepc;
	csr_data_t mcause;

	csr_data_t mstatus;
	csr_data_t mie;
	csr_data_t mip;

	// One hot: external, timer, ecall.
	logic [2:0] irq_select;
	logic [2:0] irq_issued;
	csr_data_t irq_cause;
	logic irq_issue;

	always_comb begin
		mstatus = '0;
		mstatus[MSTATUS_MIE] = mstatus_mie;
		mstatus[MSTATUS_MPIE] = mstatus_mpie;
		mie = '0;
		mie[IRQ_MEI] = mie_meie;
		mie[IRQ_MTI] = mie_mtie;
		mie[IRQ_MSI] = mie_msie;
		mip = '0;
		mip[IRQ_MEI] = mip_meip;
		mip[IRQ_MTI] = mip_mtip;
		mip[IRQ_MSI] = mip_msip;
	end

	// Read mux.
	always_comb begin
		bus.rdata = '0;
		if (bus.read) begin
			case (bus.index)
				CSR_MSTATUS: bus.rdata = mstatus;
				CSR_MIE: bus.rdata = mie;
				CSR_MTVEC: bus.rdata = mtvec;
				CSR_MSCRATCH: bus.rdata = mscratch;
				CSR_MEPC: bus.rdata = mepc;
				CSR_MCAUSE: bus.rdata = mcause;
				CSR_MIP: bus.rdata = mip;
				CSR_CYCLE: bus.rdata = i_cycle[31:0];
				CSR_CYCLEH: bus.rdata = i_cycle[63:32];
				CSR_TIME: bus.rdata = i_time[31:0];
				CSR_TIMEH: bus.rdata = i_time[63:32];
				CSR_INSTRET: bus.rdata = i_retired[31:0];
				CSR_INSTRETH: bus.rdata = i_retired[63:32];
				CSR_MVENDORID: bus.rdata = VENDORID;
				CSR_MARCHID: bus.rdata = ARCHID;
				CSR_MIMPID: bus.rdata = IMPID;
				CSR_MHARTID: bus.rdata = HARTID;
				default: bus.rdata = '0;
			endcase
		end
	end

	// Priority order external, timer, ecall.
	always_comb begin
		irq_select = 3'b000;
		irq_cause = CAUSE_ECALL;
		if (mip_meip) begin
			irq_select = 3'b100;
			irq_cause = CAUSE_EXTERNAL;
		end else if (mip_mtip) begin
			irq_select = 3'b010;
			irq_cause = CAUSE_TIMER;
		end else if (mip_msip) begin
			irq_select = 3'b001;
		end
	end

	assign irq_issue = (irq_state == IRQ_IDLE) && mstatus_mie && (|irq_select);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			irq_state <= IRQ_IDLE;
			irq_issued <= 3'b000;
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_meie <= 1'b0;
			mie_mtie <= 1'b0;
			mie_msie <= 1'b0;
			mip_meip <= 1'b0;
			mip_mtip <= 1'b0;
			mip_msip <= 1'b0;
			mtvec <= '0;
			mscratch <= '0;
			mepc <= '0;
			mcause <= '0;
		end else begin
			// Software writes first, so hardware updates below win.
			if (bus.write) begin
				case (bus.index)
					CSR_MSTATUS: begin
						mstatus_mie <= bus.wdata[MSTATUS_MIE];
						mstatus_mpie <= bus.wdata[MSTATUS_MPIE];
					end
					CSR_MIE: begin
						mie_meie <= bus.wdata[IRQ_MEI];
						mie_mtie <= bus.wdata[IRQ_MTI];
						mie_msie <= bus.wdata[IRQ_MSI];
					end
					CSR_MIP: begin
						// MEIP follows the external line only.
						mip_mtip <= bus.wdata[IRQ_MTI];
						mip_msip <= bus.wdata[IRQ_MSI];
					end
					CSR_MTVEC: mtvec <= bus.wdata;
					CSR_MSCRATCH: mscratch <= bus.wdata;
					CSR_MEPC: mepc <= bus.wdata;
					CSR_MCAUSE: mcause <= bus.wdata;
					default: ;
				endcase
			end

			// Latch enabled sources.
			if (i_external_interrupt && mie_meie) begin
				mip_meip <= 1'b1;
			end
			if (i_timer_interrupt && mie_mtie) begin
				mip_mtip <= 1'b1;
			end
			if (i_ecall && mie_msie) begin
				mip_msip <= 1'b1;
			end

			// Return from trap.
			if (i_mret) begin
				mstatus_mie <= mstatus_mpie;
				mstatus_mpie <= 1'b1;
			end

			case (irq_state)
				IRQ_IDLE: begin
					if (irq_issue) begin
						irq_state <= IRQ_PENDING;
						irq_issued <= irq_select;
						mcause <= irq_cause;
						mstatus_mpie <= mstatus_mie;
						mstatus_mie <= 1'b0;
					end
				end
				IRQ_PENDING: begin
					if (i_irq_dispatched) begin
						irq_state <= IRQ_IDLE;
						irq_issued <= 3'b000;
						mepc <= i_irq_epc;
						// Only the issued source is acknowledged.
						if (irq_issued[2]) begin
							mip_meip <= 1'b0;
						end
						if (irq_issued[1]) begin
							mip_mtip <= 1'b0;
						end
						if (irq_issued[0]) begin
							mip_msip <= 1'b0;
						end
					end
				end
				default: irq_state <= IRQ_IDLE;
			endcase
		end
	end

	// Trap vector captured at issue.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_irq_pc <= '0;
		end else if (irq_issue) begin
			o_irq_pc <= mtvec;
		end
	end

	assign o_irq_pending = (irq_state == IRQ_PENDING);
	assign o_epc = mepc;

endmodule

/* verilog/csr_counters.sv */
module csr_counters import csr_pkg::*; #(
	parameter int FREQUENCY = 1000
) (
	input logic i_clock,
	input logic i_reset,
	output counter_t o_cycle,
	output counter_t o_time
);

	// Clocks per millisecond tick.
	localparam int PRESCALE = FREQUENCY / 1000;
	localparam int PRESCALE_WIDTH = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

	logic [PRESCALE_WIDTH-1:0] prescale;
	logic tick;

	assign tick = (prescale == PRESCALE_WIDTH'(PRESCALE - 1));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_cycle <= '0;
		end else begin
			o_cycle <= o_cycle + 64'd1;
		end
	end

	// Wall time advances once per wrap.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prescale <= '0;
			o_time <= '0;
		end else begin
			if (tick) begin
				prescale <= '0;
				o_time <= o_time + 64'd1;
			end else begin
				prescale <= prescale + 1'b1;
			end
		end
	end

endmodule

/* verilog/csr_subsystem.sv */
module csr_subsystem import csr_pkg::*; #(
	parameter int FREQUENCY = 1000,
	parameter csr_data_t VENDORID = '0,
	parameter csr_data_t ARCHID = '0,
	parameter csr_data_t IMPID = '0,
	parameter csr_data_t HARTID = '0
) (
	input logic i_clock,
	input logic i_reset,

	// Core pipeline port.
	input csr_index_t i_core_index,
	input csr_data_t i_core_wdata,
	input logic i_core_write,
	input logic i_core_read,
	output csr_data_t o_core_rdata,

	// Debug port.
	input csr_index_t i_dbg_index,
	input csr_data_t i_dbg_wdata,
	input logic i_dbg_write,
	input logic i_dbg_read,
	output csr_data_t o_dbg_rdata,
	output logic o_dbg_ack,

	// Interrupt sources and trap control.
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_ecall,
	input logic i_mret,
	input logic i_irq_dispatched,
	input csr_data_t i_irq_epc,

	// Retired instruction count from the pipeline.
	input counter_t i_retired,

	output logic o_irq_pending,
	output csr_data_t o_irq_pc,
	output csr_data_t o_epc
);

	counter_t cycle;
	counter_t wall_time;

	csr_bus_if bus ();

	csr_arbiter i_csr_arbiter (
		.i_core_index(i_core_index),
		.i_core_wdata(i_core_wdata),
		.i_core_write(i_core_write),
		.i_core_read(i_core_read),
		.o_core_rdata(o_core_rdata),
		.i_dbg_index(i_dbg_index),
		.i_dbg_wdata(i_dbg_wdata),
		.i_dbg_write(i_dbg_write),
		.i_dbg_read(i_dbg_read),
		.o_dbg_rdata(o_dbg_rdata),
		.o_dbg_ack(o_dbg_ack),
		.bus(bus.requester)
	);

	csr_file #(
		.VENDORID(VENDORID),
		.ARCHID(ARCHID),
		.IMPID(IMPID),
		.HARTID(HARTID)
	) i_csr_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(bus.responder),
		.i_cycle(cycle),
		.i_time(wall_time),
		.i_retired(i_retired),
		.i_timer_interrupt(i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_ecall(i_ecall),
		.i_mret(i_mret),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc),
		.o_epc(o_epc)
	);

	csr_counters #(
		.FREQUENCY(FREQUENCY)
	) i_csr_counters (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_cycle(cycle),
		.o_time(wall_time)
	);

endmodule

/* test/csr_subsystem_chk.sv */
module csr_subsystem_chk import csr_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_irq_pending,
	input logic i_mstatus_mie,
	input csr_data_t i_mcause,
	input logic i_irq_dispatched
);

	// Issue needs global enable one cycle earlier.
	rise_needs_mie: assert property (
		@(posedge i_clock) disable iff (i_reset)
		$rose(i_irq_pending) |-> $past(i_mstatus_mie)
	) else $error("irq pending rose without MIE set");

	mie_clear_while_pending: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_irq_pending |-> !i_mstatus_mie
	) else $error("MIE set while irq pending");

	// Only the three standard codes.
	cause_is_known: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_irq_pending |-> (i_mcause == CAUSE_EXTERNAL || i_mcause == CAUSE_TIMER ||
			i_mcause == CAUSE_ECALL)
	) else $error("unexpected mcause while irq pending");

	dispatch_clears_pending: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(i_irq_pending && i_irq_dispatched) |=> !i_irq_pending
	) else $error("irq pending did not fall after dispatch");

endmodule

bind csr_file csr_subsystem_chk i_csr_subsystem_chk (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_irq_pending(o_irq_pending),
	.i_mstatus_mie(mstatus_mie),
	.i_mcause(mcause),
	.i_irq_dispatched(i_irq_dispatched)
);

/* test/csr_subsystem_tb.sv */
module csr_subsystem_tb import csr_pkg::*; ();

	localparam int PERIOD = 4;
	localparam csr_data_t VENDOR_ID = 32'h0000_0601;
	localparam csr_data_t ARCH_ID = 32'h0000_0023;
	localparam csr_data_t IMP_ID = 32'h0001_0002;
	localparam csr_data_t HART_ID = 32'h0000_0003;
	localparam counter_t RETIRED = 64'h0000_0012_3456_789A;

	// Unused CSR address.
	localparam csr_index_t CSR_UNUSED = 12'h7C0;

	typedef enum {
		OP_CORE_WR,
		OP_CORE_RD,
		OP_DBG_WR,
		OP_DBG_RD,
		OP_SIMUL,
		OP_RAISE,
		OP_TRAP_PC,
		OP_DISPATCH,
		OP_MRET,
		OP_DELTA,
		OP_WAIT
	} op_t;

	typedef struct {
		string name;
		op_t op;
		csr_index_t index;
		csr_data_t data;
		csr_data_t expected;
	} test_row_t;

	logic i_clock;
	logic i_reset;
	csr_index_t i_core_index;
	csr_data_t i_core_wdata;
	logic i_core_write;
	logic i_core_read;
	csr_data_t o_core_rdata;
	csr_index_t i_dbg_index;
	csr_data_t i_dbg_wdata;
	logic i_dbg_write;
	logic i_dbg_read;
	csr_data_t o_dbg_rdata;
	logic o_dbg_ack;
	logic i_timer_interrupt;
	logic i_external_interrupt;
	logic i_ecall;
	logic i_mret;
	logic i_irq_dispatched;
	csr_data_t i_irq_epc;
	counter_t i_retired;
	logic o_irq_pending;
	csr_data_t o_irq_pc;
	csr_data_t o_epc;

	test_row_t rows[$];
	integer seed = 32'h60d84576;
	csr_data_t scratch_pattern;
	int pass_count = 0;
	int fail_count = 0;
	logic row_failed;

	csr_subsystem #(
		.FREQUENCY(4000),
		.VENDORID(VENDOR_ID),
		.ARCHID(ARCH_ID),
		.IMPID(IMP_ID),
		.HARTID(HART_ID)
	) i_csr_subsystem (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_core_index(i_core_index),
		.i_core_wdata(i_core_wdata),
		.i_core_write(i_core_write),
		.i_core_read(i_core_read),
		.o_core_rdata(o_core_rdata),
		.i_dbg_index(i_dbg_index),
		.i_dbg_wdata(i_dbg_wdata),
		.i_dbg_write(i_dbg_write),
		.i_dbg_read(i_dbg_read),
		.o_dbg_rdata(o_dbg_rdata),
		.o_dbg_ack(o_dbg_ack),
		.i_timer_interrupt(i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_ecall(i_ecall),
		.i_mret(i_mret),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.i_retired(i_retired),
		.o_irq_pending(o_irq_pending),
		.o_irq_pc(o_irq_pc),
		.o_epc(o_epc)
	);

	initial i_clock = 1'b0;
	always #(PERIOD / 2) i_clock = ~i_clock;

	task automatic add_row(input string name, input op_t op, input csr_index_t index,
			input csr_data_t data, input csr_data_t expected);
		test_row_t row;
		row.name = name;
		row.op = op;
		row.index = index;
		row.data = data;
		row.expected = expected;
		rows.push_back(row);
	endtask

	task automatic clear_strobes();
		i_core_write = 1'b0;
		i_core_read = 1'b0;
		i_dbg_write = 1'b0;
		i_dbg_read = 1'b0;
		i_timer_interrupt = 1'b0;
		i_external_interrupt = 1'b0;
		i_ecall = 1'b0;
		i_mret = 1'b0;
		i_irq_dispatched = 1'b0;
	endtask

	task automatic check_value(input string name, input csr_data_t expected,
			input csr_data_t actual);
		if (actual !== expected) begin
			$display("ERR %s expected %08h actual %08h", name, expected, actual);
			row_failed = 1'b1;
		end
	endtask

	task automatic report_problem(input string name, input string text);
		$display("%s: %s", name, text);
		row_failed = 1'b1;
	endtask

	// Each row starts on a falling edge; reads sample one unit later.
	task automatic run_row(input test_row_t row);
		csr_data_t first;
		csr_data_t second;
		row_failed = 1'b0;
		@(negedge i_clock);
		clear_strobes();
		case (row.op)
			OP_CORE_WR: begin
				i_core_index = row.index;
				i_core_wdata = row.data;
				i_core_write = 1'b1;
			end
			OP_CORE_RD: begin
				i_core_index = row.index;
				i_core_read = 1'b1;
				#1;
				check_value(row.name, row.expected, o_core_rdata);
			end
			OP_DBG_WR: begin
				i_dbg_index = row.index;
				i_dbg_wdata = row.data;
				i_dbg_write = 1'b1;
				#1;
				if (o_dbg_ack !== 1'b1) begin
					report_problem(row.name, "debug write was not acknowledged");
				end
			end
			OP_DBG_RD: begin
				i_dbg_index = row.index;
				i_dbg_read = 1'b1;
				#1;
				if (o_dbg_ack !== 1'b1) begin
					report_problem(row.name, "debug read was not acknowledged");
				end
				check_value(row.name, row.expected, o_dbg_rdata);
			end
			OP_SIMUL: begin
				// Data field carries the debug index.
				i_core_index = row.index;
				i_core_read = 1'b1;
				i_dbg_index = row.data[11:0];
				i_dbg_read = 1'b1;
				#1;
				if (o_dbg_ack !== 1'b0) begin
					report_problem(row.name, "debug access acknowledged while core held the bus");
				end
				check_value(row.name, row.expected, o_core_rdata);
			end
			OP_RAISE: begin
				// Bits 2..0 select external, timer, ecall.
				i_external_interrupt = row.data[2];
				i_timer_interrupt = row.data[1];
				i_ecall = row.data[0];
				@(negedge i_clock);
				clear_strobes();
				@(negedge i_clock);
				#1;
				check_value(row.name, row.expected, {31'b0, o_irq_pending});
			end
			OP_TRAP_PC: begin
				#1;
				check_value(row.name, row.expected, o_irq_pc);
			end
			OP_DISPATCH: begin
				i_irq_epc = row.data;
				i_irq_dispatched = 1'b1;
				@(negedge i_clock);
				clear_strobes();
				#1;
				check_value(row.name, row.expected, o_epc);
				if (o_irq_pending !== 1'b0) begin
					report_problem(row.name, "interrupt still pending after dispatch");
				end
			end
			OP_MRET: begin
				i_mret = 1'b1;
				@(negedge i_clock);
				clear_strobes();
				@(negedge i_clock);
				#1;
				check_value(row.name, row.expected, {31'b0, o_irq_pending});
			end
			OP_DELTA: begin
				// Two reads of one index, data cycles apart.
				i_core_index = row.index;
				i_core_read = 1'b1;
				#1;
				first = o_core_rdata;
				repeat (row.data) @(negedge i_clock);
				#1;
				second = o_core_rdata;
				check_value(row.name, row.expected, second - first);
			end
			OP_WAIT: begin
				repeat (row.data) @(negedge i_clock);
			end
			default: report_problem(row.name, "unknown operation in the table");
		endcase
		if (row_failed) begin
			fail_count++;
		end else begin
			pass_count++;
			$display("ok   %s", row.name);
		end
	endtask

	task automatic build_table();
		scratch_pattern = $random(seed);
		add_row("reset mstatus", OP_CORE_RD, CSR_MSTATUS, 0, 32'h0);
		add_row("reset mie", OP_CORE_RD, CSR_MIE, 0, 32'h0);
		add_row("reset mtvec", OP_CORE_RD, CSR_MTVEC, 0, 32'h0);
		add_row("reset no irq", OP_RAISE, 0, 32'h0, 32'h0);
		add_row("reset trap pc", OP_TRAP_PC, 0, 0, 32'h0);
		add_row("mtvec write", OP_CORE_WR, CSR_MTVEC, 32'hFFFF_FFFF, 0);
		add_row("mtvec read", OP_CORE_RD, CSR_MTVEC, 0, 32'hFFFF_FFFF);
		add_row("mscratch write", OP_CORE_WR, CSR_MSCRATCH, 32'hFFFF_FFFF, 0);
		add_row("mscratch read", OP_CORE_RD, CSR_MSCRATCH, 0, 32'hFFFF_FFFF);
		add_row("mepc write", OP_CORE_WR, CSR_MEPC, 32'hFFFF_FFFF, 0);
		add_row("mepc read", OP_CORE_RD, CSR_MEPC, 0, 32'hFFFF_FFFF);
		add_row("mstatus write", OP_CORE_WR, CSR_MSTATUS, 32'hFFFF_FFFF, 0);
		add_row("mstatus mask", OP_CORE_RD, CSR_MSTATUS, 0, 32'h0000_0088);
		add_row("mstatus clear", OP_CORE_WR, CSR_MSTATUS, 32'h0, 0);
		add_row("mie write", OP_CORE_WR, CSR_MIE, 32'hFFFF_FFFF, 0);
		add_row("mie mask", OP_CORE_RD, CSR_MIE, 0, 32'h0000_0888);
		add_row("mip write", OP_CORE_WR, CSR_MIP, 32'hFFFF_FFFF, 0);
		add_row("mip no meip", OP_CORE_RD, CSR_MIP, 0, 32'h0000_0088);
		add_row("mip clear", OP_CORE_WR, CSR_MIP, 32'h0, 0);
		add_row("mip cleared", OP_CORE_RD, CSR_MIP, 0, 32'h0);
		add_row("mvendorid", OP_CORE_RD, CSR_MVENDORID, 0, VENDOR_ID);
		add_row("marchid", OP_CORE_RD, CSR_MARCHID, 0, ARCH_ID);
		add_row("mimpid", OP_CORE_RD, CSR_MIMPID, 0, IMP_ID);
		add_row("mhartid", OP_CORE_RD, CSR_MHARTID, 0, HART_ID);
		add_row("unused write", OP_CORE_WR, CSR_UNUSED, 32'h1234_5678, 0);
		add_row("unused read", OP_CORE_RD, CSR_UNUSED, 0, 32'h0);
		add_row("unused no effect", OP_CORE_RD, CSR_MSCRATCH, 0, 32'hFFFF_FFFF);
		add_row("vector setup", OP_CORE_WR, CSR_MTVEC, 32'h0000_0100, 0);
		add_row("enable all", OP_CORE_WR, CSR_MIE, 32'h0000_0888, 0);
		add_row("global enable", OP_CORE_WR, CSR_MSTATUS, 32'h0000_0008, 0);
		add_row("raise all", OP_RAISE, 0, 32'h7, 32'h1);
		add_row("trap pc", OP_TRAP_PC, 0, 0, 32'h0000_0100);
		add_row("cause external", OP_CORE_RD, CSR_MCAUSE, 0, CAUSE_EXTERNAL);
		add_row("mie pushed", OP_CORE_RD, CSR_MSTATUS, 0, 32'h0000_0080);
		add_row("all latched", OP_CORE_RD, CSR_MIP, 0, 32'h0000_0888);
		add_row("dispatch external", OP_DISPATCH, 0, 32'h0000_1000, 32'h0000_1000);
		add_row("mepc external", OP_CORE_RD, CSR_MEPC, 0, 32'h0000_1000);
		add_row("meip cleared", OP_CORE_RD, CSR_MIP, 0, 32'h0000_0088);
		add_row("mret to timer", OP_MRET, 0, 0, 32'h1);
		add_row("cause timer", OP_CORE_RD, CSR_MCAUSE, 0, CAUSE_TIMER);
		add_row("dispatch timer", OP_DISPATCH, 0, 32'h0000_2000, 32'h0000_2000);
		add_row("mtip cleared", OP_CORE_RD, CSR_MIP, 0, 32'h0000_0008);
		add_row("mret to ecall", OP_MRET, 0, 0, 32'h1);
		add_row("cause ecall", OP_CORE_RD, CSR_MCAUSE, 0, CAUSE_ECALL);
		add_row("dispatch ecall", OP_DISPATCH, 0, 32'h0000_3000, 32'h0000_3000);
		add_row("msip cleared", OP_CORE_RD, CSR_MIP, 0, 32'h0);
		add_row("mret idle", OP_MRET, 0, 0, 32'h0);
		add_row("mie restored", OP_CORE_RD, CSR_MSTATUS, 0, 32'h0000_0088);
		add_row("external only", OP_CORE_WR, CSR_MIE, 32'h0000_0800, 0);
		add_row("masked timer", OP_RAISE, 0, 32'h2, 32'h0);
		add_row("masked not latched", OP_CORE_RD, CSR_MIP, 0, 32'h0);
		add_row("scratch pattern", OP_CORE_WR, CSR_MSCRATCH, scratch_pattern, 0);
		add_row("core wins", OP_SIMUL, CSR_MTVEC, {20'h0, CSR_MSCRATCH}, 32'h0000_0100);
		add_row("debug served", OP_DBG_RD, CSR_MSCRATCH, 0, scratch_pattern);
		add_row("debug write", OP_DBG_WR, CSR_MSCRATCH, 32'hA5A5_5A5A, 0);
		add_row("debug write seen", OP_CORE_RD, CSR_MSCRATCH, 0, 32'hA5A5_5A5A);
		add_row("cycle delta", OP_DELTA, CSR_CYCLE, 32'd20, 32'd20);
		add_row("cycleh", OP_CORE_RD, CSR_CYCLEH, 0, 32'h0);
		add_row("time delta", OP_DELTA, CSR_TIME, 32'd20, 32'd5);
		add_row("idle gap", OP_WAIT, 0, 32'd3, 0);
		add_row("instret", OP_CORE_RD, CSR_INSTRET, 0, RETIRED[31:0]);
		add_row("instreth", OP_CORE_RD, CSR_INSTRETH, 0, RETIRED[63:32]);
	endtask

	initial begin
		build_table();
		clear_strobes();
		i_reset = 1'b1;
		i_core_index = '0;
		i_core_wdata = '0;
		i_dbg_index = '0;
		i_dbg_wdata = '0;
		i_irq_epc = '0;
		i_retired = RETIRED;
		repeat (10) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		foreach (rows[k]) begin
			run_row(rows[k]);
		end
		@(negedge i_clock);
		clear_strobes();
		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// Watchdog sized from the table length.
	initial begin
		#1;
		repeat (rows.size() * 50 + 10) @(posedge i_clock);
		$display("Run timed out before the test table finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* project.f */
verilog/csr_pkg.sv
verilog/csr_bus_if.sv
verilog/csr_arbiter.sv
verilog/csr_file.sv
verilog/csr_counters.sv
verilog/csr_subsystem.sv
test/csr_subsystem_chk.sv
test/csr_subsystem_tb.sv

/* Makefile */
TOP := csr_subsystem_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f $(wildcard verilog/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" sim.log; then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
